//--- list.f
rtl/sram_ctrl_pkg.sv
rtl/sram_req_if.sv
rtl/apb_sram_port.sv
rtl/sram_fsm.sv
rtl/sram_pin_driver.sv
rtl/sram_apb_top.sv
sim/sram_async_model.sv
sim/tb_sram_apb.sv

//--- Bender.yml
package:
  name: sram_apb_ctrl

sources:
  - rtl/sram_ctrl_pkg.sv
  - rtl/sram_req_if.sv
  - rtl/apb_sram_port.sv
  - rtl/sram_fsm.sv
  - rtl/sram_pin_driver.sv
  - rtl/sram_apb_top.sv
  - target: simulation
    files:
      - sim/sram_async_model.sv
      - sim/tb_sram_apb.sv

//--- sim/tb_sram_apb.sv
module tb_sram_apb;

  localparam int ADDR_W      = sram_ctrl_pkg::DEF_ADDR_W;
  localparam int DATA_W      = sram_ctrl_pkg::DEF_DATA_W;
  localparam int CLK_PERIOD  = 8;
  localparam int DRIVE_DLY   = 1;
  localparam int NUM_RANDOM  = 300;
  localparam int NUM_XFERS   = NUM_RANDOM + 3;
  localparam int EXP_LATENCY = 4;
  localparam int WINDOW_SIZE = 16;
  localparam logic [ADDR_W-1:0] WINDOW_BASE    = 'h100;
  localparam logic [ADDR_W-1:0] UNWRITTEN_ADDR = 'h200; // Outside the random window.

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [ADDR_W-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic              pready;
  logic [DATA_W-1:0] prdata;
  logic [ADDR_W-1:0] sram_addr;
  logic [DATA_W-1:0] sram_dq_o;
  logic              sram_dq_oe;
  logic [DATA_W-1:0] sram_dq_i;
  logic              sram_ce_n;
  logic              sram_oe_n;
  logic              sram_we_n;

  logic [DATA_W-1:0] ref_mem [2**ADDR_W];
  logic [ADDR_W-1:0] t_addr;
  logic [DATA_W-1:0] t_data;
  logic [DATA_W-1:0] rd;
  logic              t_write;
  int                lat;

  sram_apb_top #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) sram_apb_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pready     (pready),
    .prdata     (prdata),
    .sram_addr  (sram_addr),
    .sram_dq_o  (sram_dq_o),
    .sram_dq_oe (sram_dq_oe),
    .sram_dq_i  (sram_dq_i),
    .sram_ce_n  (sram_ce_n),
    .sram_oe_n  (sram_oe_n),
    .sram_we_n  (sram_we_n)
  );

  sram_async_model #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) sram_model_inst (
    .addr   (sram_addr),
    .dq_in  (sram_dq_o),
    .dq_oe  (sram_dq_oe),
    .dq_out (sram_dq_i),
    .ce_n   (sram_ce_n),
    .oe_n   (sram_oe_n),
    .we_n   (sram_we_n)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_rdata(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_with_failure($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // Bits are {pready, ce_n, oe_n, we_n, dq_oe}.
  task automatic check_pins(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // One APB transfer, entered and left 1 time unit after a rising edge.
  task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output int cycles);
    psel    = 1'b1; // Setup phase.
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #DRIVE_DLY;
    penable = 1'b1;
    cycles  = 1;
    while (pready !== 1'b1) begin
      @(posedge clk);
      #DRIVE_DLY;
      cycles++;
    end
    rdata = prdata;
    @(posedge clk);
    #DRIVE_DLY;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  // Strobe exclusion is watched on every edge while out of reset.
  always @(posedge clk) begin
    if (rst_n === 1'b1) begin
      if (!sram_oe_n && !sram_we_n) begin
        stop_with_failure("Output enable and write enable were low at the same time.");
      end
      if (sram_dq_oe && !sram_oe_n) begin
        stop_with_failure("The data bus was driven while output enable was low.");
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_XFERS * 6 + 100));
    stop_with_failure("Timeout: the transfers did not finish in the allowed time.");
  end

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    void'($urandom(32'ha72632f1));
    for (int i = 0; i < 2**ADDR_W; i++) begin
      ref_mem[i] = '0;
    end

    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    idle_cycles(1);
    check_pins("reset_state", 5'b01110, {pready, sram_ce_n, sram_oe_n, sram_we_n, sram_dq_oe});

    t_addr = WINDOW_BASE + ADDR_W'(3);
    t_data = DATA_W'($urandom);
    apb_transfer(1'b1, t_addr, t_data, rd, lat);
    check_latency("directed_write", EXP_LATENCY, lat);
    ref_mem[t_addr] = t_data;
    check_rdata("model_after_write", ref_mem[t_addr], sram_model_inst.mem[t_addr]);
    apb_transfer(1'b0, t_addr, '0, rd, lat);
    check_latency("directed_read", EXP_LATENCY, lat);
    check_rdata("directed_readback", ref_mem[t_addr], rd);

    apb_transfer(1'b0, UNWRITTEN_ADDR, '0, rd, lat);
    check_latency("unwritten_read", EXP_LATENCY, lat);
    check_rdata("unwritten_read", DATA_W'(0), rd);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      t_write = 1'($urandom_range(0, 1));
      t_addr  = WINDOW_BASE + ADDR_W'($urandom_range(0, WINDOW_SIZE - 1));
      t_data  = DATA_W'($urandom);
      apb_transfer(t_write, t_addr, t_data, rd, lat);
      check_latency($sformatf("random_latency_%0d", i), EXP_LATENCY, lat);
      if (t_write) begin
        ref_mem[t_addr] = t_data; // Last write to an address wins.
      end else begin
        check_rdata($sformatf("random_read_%0d", i), ref_mem[t_addr], rd);
      end
      idle_cycles($urandom_range(0, 1));
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- sim/sram_async_model.sv
module sram_async_model #(
  parameter int ADDR_W = sram_ctrl_pkg::DEF_ADDR_W,
  parameter int DATA_W = sram_ctrl_pkg::DEF_DATA_W
) (
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] dq_in,  // Data driven by the controller.
  input  logic              dq_oe,  // Controller drives the bus.
  output logic [DATA_W-1:0] dq_out, // Data driven by the chip.
  input  logic              ce_n,
  input  logic              oe_n,
  input  logic              we_n
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem[i] = '0;
    end
  end

  // The chip drives the bus only while selected with output enable low.
  assign dq_out = (!ce_n && !oe_n) ? mem[addr] : 'z;

  // Write enable falls back to inactive at the end of the write pulse,
  // and the word on the bus is stored at that moment.
  always @(posedge we_n) begin
    if (dq_oe === 1'b1) begin
      mem[addr] = dq_in;
    end
  end

endmodule

//--- rtl/sram_apb_top.sv
module sram_apb_top #(
  parameter int ADDR_W = sram_ctrl_pkg::DEF_ADDR_W,
  parameter int DATA_W = sram_ctrl_pkg::DEF_DATA_W
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic              pready,
  output logic [DATA_W-1:0] prdata,

  output logic [ADDR_W-1:0] sram_addr,
  output logic [DATA_W-1:0] sram_dq_o,
  output logic              sram_dq_oe,
  input  logic [DATA_W-1:0] sram_dq_i,
  output logic              sram_ce_n,
  output logic              sram_oe_n,
  output logic              sram_we_n
);

  sram_ctrl_pkg::state_t state;
  logic                  latch_read;
  logic                  drive_data_en;

  sram_req_if #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) req_if ();

  apb_sram_port #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) apb_sram_port_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready),
    .prdata  (prdata),
    .req     (req_if.port)
  );

  sram_fsm sram_fsm_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .seq           (req_if.seq),
    .state         (state),
    .latch_read    (latch_read),
    .drive_data_en (drive_data_en),
    .sram_ce_n     (sram_ce_n),
    .sram_oe_n     (sram_oe_n),
    .sram_we_n     (sram_we_n)
  );

  sram_pin_driver #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) sram_pin_driver_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .pins          (req_if.pins),
    .state         (state),
    .latch_read    (latch_read),
    .drive_data_en (drive_data_en),
    .sram_addr     (sram_addr),
    .sram_dq_o     (sram_dq_o),
    .sram_dq_oe    (sram_dq_oe),
    .sram_dq_i     (sram_dq_i)
  );

endmodule

//--- rtl/sram_pin_driver.sv
module sram_pin_driver #(
  parameter int ADDR_W,
  parameter int DATA_W
) (
  input  logic                  clk,
  input  logic                  rst_n,

  sram_req_if.pins              pins,

  input  sram_ctrl_pkg::state_t state,
  input  logic                  latch_read,
  input  logic                  drive_data_en,

  output logic [ADDR_W-1:0]     sram_addr,
  output logic [DATA_W-1:0]     sram_dq_o,
  output logic                  sram_dq_oe,
  input  logic [DATA_W-1:0]     sram_dq_i
);

  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] wdata_q;
  logic [DATA_W-1:0] rdata_q;
  logic              wr_q;    // Current access is a write.

  // Address and data are taken on the request, so the pins settle
  // as the sequencer enters READ or WRITE.
  always_ff @(posedge clk) begin
    if (pins.read_req || pins.write_req) begin
      addr_q  <= pins.addr;
      wdata_q <= pins.wdata;
    end
    if (latch_read) begin
      rdata_q <= sram_dq_i; // Sampled at the edge that ends READ.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_q <= 1'b0;
    end else if (pins.read_req || pins.write_req) begin
      wr_q <= pins.write_req;
    end
  end

  assign sram_addr  = addr_q;
  assign sram_dq_o  = wdata_q;
  assign sram_dq_oe = drive_data_en;
  assign pins.rdata = rdata_q;

  // The SRAM drives the bus in READ.
  a_no_drive_in_read : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == sram_ctrl_pkg::READ) |-> !sram_dq_oe
  );

  // Only a write access may put data on the bus.
  a_drive_only_for_write : assert property (
    @(posedge clk) disable iff (!rst_n)
    drive_data_en |-> wr_q
  );

endmodule

//--- rtl/sram_fsm.sv
module sram_fsm (
  input  logic                  clk,
  input  logic                  rst_n,

  sram_req_if.seq               seq,

  output sram_ctrl_pkg::state_t state,
  output logic                  latch_read,
  output logic                  drive_data_en,

  output logic                  sram_ce_n,
  output logic                  sram_oe_n,
  output logic                  sram_we_n
);

  sram_ctrl_pkg::state_t next_state;
  logic                  op_write; // Operation of the current access.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= sram_ctrl_pkg::IDLE;
      op_write <= 1'b0;
    end else begin
      state <= next_state;
      if (state == sram_ctrl_pkg::IDLE && (seq.write_req || seq.read_req)) begin
        op_write <= seq.write_req;
      end
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      sram_ctrl_pkg::IDLE: begin
        if (seq.write_req) next_state = sram_ctrl_pkg::WRITE; // Write wins a tie.
        else if (seq.read_req) next_state = sram_ctrl_pkg::READ;
      end
      sram_ctrl_pkg::READ:  next_state = sram_ctrl_pkg::DONE;
      sram_ctrl_pkg::WRITE: next_state = sram_ctrl_pkg::DONE;
      sram_ctrl_pkg::DONE:  next_state = sram_ctrl_pkg::IDLE;
      default:              next_state = sram_ctrl_pkg::IDLE;
    endcase
  end

  assign seq.ready  = (state == sram_ctrl_pkg::IDLE);
  assign latch_read = (state == sram_ctrl_pkg::READ);

  // Data stays on the bus through the DONE after a write, so it is held past
  // the rising edge of write enable.
  assign drive_data_en = (state == sram_ctrl_pkg::WRITE) ||
                         (state == sram_ctrl_pkg::DONE && op_write);

  assign sram_ce_n = !(state == sram_ctrl_pkg::READ || state == sram_ctrl_pkg::WRITE);
  assign sram_oe_n = !(state == sram_ctrl_pkg::READ);
  assign sram_we_n = !(state == sram_ctrl_pkg::WRITE);

  // Write data must still be on the bus when write enable rises.
  a_data_hold_at_we_rise : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(sram_we_n) |-> drive_data_en
  );

  // The bus side must wait for IDLE before it issues the next request.
  a_req_when_ready : assert property (
    @(posedge clk) disable iff (!rst_n)
    (seq.read_req || seq.write_req) |-> seq.ready
  );

endmodule

//--- rtl/apb_sram_port.sv
module apb_sram_port #(
  parameter int ADDR_W,
  parameter int DATA_W
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic              pready,
  output logic [DATA_W-1:0] prdata,

  sram_req_if.port          req
);

  logic pending;
  logic issue;

  // A transfer is handed to the sequencer in its first access cycle only.
  // While pending is set the same transfer is never issued twice.
  assign issue = psel && penable && !pending && req.ready;

  assign req.write_req = issue && pwrite;
  assign req.read_req  = issue && !pwrite;

  // APB keeps PADDR and PWDATA stable until PREADY, so the request
  // fields can come straight from the bus.
  assign req.addr  = paddr;
  assign req.wdata = pwdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (issue) begin
      pending <= 1'b1;
    end else if (pending && req.ready) begin
      pending <= 1'b0; // Transfer completes in this cycle.
    end
  end

  // The sequencer is back in IDLE three cycles after the request,
  // which is the fourth access cycle of the transfer.
  assign pready = pending && req.ready;
  assign prdata = req.rdata; // Captured at the end of READ, valid with PREADY.

  // PREADY must only rise inside an access phase.
  a_pready_in_access : assert property (
    @(posedge clk) disable iff (!rst_n)
    pready |-> (psel && penable)
  );

  // The pin registers latched PADDR at the request, but the master must still hold it.
  a_paddr_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    pending |-> $stable(paddr)
  );

endmodule

//--- rtl/sram_req_if.sv
interface sram_req_if #(
  parameter int ADDR_W = sram_ctrl_pkg::DEF_ADDR_W,
  parameter int DATA_W = sram_ctrl_pkg::DEF_DATA_W
);

  logic              read_req;  // One-cycle strobe, only while ready is high.
  logic              write_req; // One-cycle strobe, only while ready is high.
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              ready;     // Sequencer is in IDLE.

  // Bus side, issues requests.
  modport port (
    output read_req,
    output write_req,
    output addr,
    output wdata,
    input  ready,
    input  rdata
  );

  // Strobe sequencer.
  modport seq (
    input  read_req,
    input  write_req,
    output ready
  );

  // Pin registers and read capture.
  modport pins (
    input  read_req,
    input  write_req,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

//--- rtl/sram_ctrl_pkg.sv
package sram_ctrl_pkg;

  // Default geometry of the external SRAM.
  // The top level picks these up and passes them down as parameters.
  parameter int DEF_ADDR_W = 16;
  parameter int DEF_DATA_W = 16;

  // Sequencer states for a single SRAM access.
  // Every access passes through DONE before the sequencer is ready again,
  // so the chip is deselected for at least one cycle between accesses.
  typedef enum logic [1:0] {
    IDLE  = 2'b00, // Ready for a new request.
    READ  = 2'b01, // CE and OE low, read data captured at the end.
    WRITE = 2'b10, // CE and WE low, data driven.
    DONE  = 2'b11  // Strobes released.
  } state_t;

endpackage
